/* Makefile */
# Verilator build and run for the TCDM stream subsystem.
VERILATOR ?= verilator
TOP       ?= tb_tcdm_stream_subsys
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
hdl/hci_pkg.sv
hdl/stream_job_pkg.sv
hdl/hci_core_mux_static.sv
hdl/tcdm_mem_bank.sv
hdl/stream_fifo.sv
hdl/hci_load_streamer.sv
hdl/hci_store_streamer.sv
hdl/hci_job_ctrl.sv
hdl/tcdm_stream_subsys.sv
dv/tcdm_stream_subsys_sva.sv
dv/tb_tcdm_stream_subsys.sv

/* dv/tb_tcdm_stream_subsys.sv */
/*
  Testbench for tcdm_stream_subsys: store then load round trips
  with random bank stalls, stream gaps and read back-pressure.
  bases stay below 1 KiB, so words map one to one onto the bank.
*/
module tb_tcdm_stream_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import hci_pkg::*;
  import stream_job_pkg::*;

  localparam int N_RT = 5;
  localparam int CLK_PERIOD = 10;
  localparam logic [HCI_AW-1:0] RT_BASE [N_RT] = '{16'h0040, 16'h0100, 16'h0180, 16'h0200,
                                                  16'h0380};
  localparam logic [LEN_W-1:0] RT_LEN [N_RT] = '{8'd12, 8'd0, 8'd1, 8'd40, 8'd30};

  logic              clk;
  logic              rst_i;
  logic              start_i;
  job_op_e           op_i;
  logic [HCI_AW-1:0] base_i;
  logic [LEN_W-1:0]  len_i;
  logic              busy_o;
  logic              done_o;
  logic              bank_stall_i;
  logic              rd_valid_o;
  logic [HCI_DW-1:0] rd_data_o;
  logic              rd_ready_i;
  logic              wr_valid_i;
  logic [HCI_DW-1:0] wr_data_i;
  logic              wr_ready_o;

  // reference memory and running job state.
  logic [HCI_DW-1:0] ref_mem [MEM_WORDS];
  logic [HCI_DW-1:0] wr_q [$];
  logic [31:0]       rng_state = 32'd42932;
  job_op_e           cur_op;
  int                exp_len;
  int                rd_cnt;
  int                wr_cnt;
  logic [MEM_AW-1:0] rd_idx;
  bit                job_finished;

  tcdm_stream_subsys DUT (
    .clk_i        (clk),
    .rst_i        (rst_i),
    .start_i      (start_i),
    .op_i         (op_i),
    .base_i       (base_i),
    .len_i        (len_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .bank_stall_i (bank_stall_i),
    .rd_valid_o   (rd_valid_o),
    .rd_data_o    (rd_data_o),
    .rd_ready_i   (rd_ready_i),
    .wr_valid_i   (wr_valid_i),
    .wr_data_i    (wr_data_i),
    .wr_ready_o   (wr_ready_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // zero length runs as a single word.
  function automatic int job_words(input logic [LEN_W-1:0] len);
    return (len == '0) ? 1 : int'(len);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, exp, act);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // one job, plus a stray start while busy on longer jobs.
  task automatic run_job(input job_op_e op, input logic [HCI_AW-1:0] base,
                         input logic [LEN_W-1:0] len);
    logic [MEM_AW-1:0] idx;
    logic [HCI_DW-1:0] w;
    @(negedge clk);
    idx = base[WORD_OFFS +: MEM_AW];
    cur_op = op;
    exp_len = job_words(len);
    rd_cnt = 0;
    wr_cnt = 0;
    rd_idx = idx;
    job_finished = 1'b0;
    if (op == JOB_STORE) begin
      for (int k = 0; k < exp_len; k++) begin
        w = next_random();
        ref_mem[idx] = w;
        wr_q.push_back(w);
        idx++;
      end
    end
    @(posedge clk);
    start_i <= 1'b1;
    op_i    <= op;
    base_i  <= base;
    len_i   <= len;
    @(posedge clk);
    start_i <= 1'b0;
    if (exp_len >= 8) begin
      @(posedge clk);
      @(posedge clk);
      start_i <= 1'b1;
      op_i    <= (op == JOB_LOAD) ? JOB_STORE : JOB_LOAD;
      base_i  <= '0;
      len_i   <= 8'd5;
      @(posedge clk);
      start_i <= 1'b0;
    end
    while (!job_finished) @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // stalls, ready gaps, store stream driver and load stream sink.
  always @(posedge clk) begin
    bank_stall_i <= (next_random() % 4) == 0;
    rd_ready_i   <= (next_random() % 3) != 0;
    if (wr_valid_i && wr_ready_o) begin
      void'(wr_q.pop_front());
      wr_cnt++;
    end
    // valid holds with its word until taken.
    if (wr_valid_i && !wr_ready_o) begin
      wr_valid_i <= 1'b1;
    end else if (wr_q.size() != 0 && (next_random() % 4) != 0) begin
      wr_valid_i <= 1'b1;
      wr_data_i  <= wr_q[0];
    end else begin
      wr_valid_i <= 1'b0;
    end
    if (rd_valid_o && rd_ready_i) begin
      assert (rd_cnt < exp_len)
        else report_error("load stream delivered more words than the job length");
      assert (rd_data_o == ref_mem[rd_idx])
        else report_mismatch("rd_data_o", ref_mem[rd_idx], rd_data_o);
      rd_idx++;
      rd_cnt++;
    end
    // word counts at the end of each job.
    if (done_o) begin
      if (cur_op == JOB_LOAD) begin
        assert (rd_cnt == exp_len) else report_mismatch("rd_valid_o handshakes", exp_len, rd_cnt);
      end else begin
        assert (wr_cnt == exp_len) else report_mismatch("wr_ready_o handshakes", exp_len, wr_cnt);
      end
      job_finished = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (DUT.i_sva.err_cnt != 0) begin
      report_error("a bound protocol assertion failed");
    end
  end

  // watchdog, 20 cycles per job word plus margin.
  initial begin
    int words;
    words = 0;
    for (int i = 0; i < N_RT; i++) begin
      words += 2 * job_words(RT_LEN[i]);
    end
    #((words * 20 + 500) * CLK_PERIOD);
    report_error("timeout: jobs did not complete within the watchdog limit");
  end

  initial begin
    rst_i        = 1'b1;
    start_i      = 1'b0;
    op_i         = JOB_LOAD;
    base_i       = '0;
    len_i        = '0;
    bank_stall_i = 1'b0;
    rd_ready_i   = 1'b0;
    wr_valid_i   = 1'b0;
    wr_data_i    = '0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    assert (!busy_o) else report_mismatch("busy_o", 0, busy_o);
    assert (!done_o) else report_mismatch("done_o", 0, done_o);
    assert (!rd_valid_o) else report_mismatch("rd_valid_o", 0, rd_valid_o);
    assert (!wr_ready_o) else report_mismatch("wr_ready_o", 0, wr_ready_o);
    for (int i = 0; i < N_RT; i++) begin
      run_job(JOB_STORE, RT_BASE[i], RT_LEN[i]);
      run_job(JOB_LOAD, RT_BASE[i], RT_LEN[i]);
    end
    repeat (5) @(posedge clk);
    if (DUT.i_sva.err_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

/* dv/tcdm_stream_subsys_sva.sv */
/*
  Protocol checks bound into tcdm_stream_subsys.
  every failing assertion also bumps err_cnt, which the testbench polls.
*/
module tcdm_stream_subsys_sva (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       start_i,
  input logic                       busy_o,
  input logic                       done_o,
  input logic                       bank_stall_i,
  input logic                       rd_valid_o,
  input logic [hci_pkg::HCI_DW-1:0] rd_data_o,
  input logic                       rd_ready_i,
  input logic                       wr_ready_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import hci_pkg::*;

  int unsigned err_cnt;

  initial err_cnt = 0;

  // one reset edge leaves job and stream outputs idle.
  a_reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !busy_o && !done_o && !rd_valid_o && !wr_ready_o)
    else begin $error("outputs not idle after reset"); err_cnt++; end

  // done is a single-cycle pulse.
  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |=> !done_o)
    else begin $error("done_o high for more than one cycle"); err_cnt++; end

  // busy drops in the done cycle, never on its own.
  a_busy_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(busy_o) |-> done_o)
    else begin $error("busy_o fell without done_o"); err_cnt++; end
  a_done_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |-> !busy_o && $past(busy_o))
    else begin $error("done_o not aligned with busy_o falling"); err_cnt++; end

  // accepted start shows as busy one cycle later.
  a_busy_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    start_i && !busy_o |=> busy_o)
    else begin $error("busy_o did not follow an idle start_i"); err_cnt++; end
  a_rise_cause: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(busy_o) |-> $past(start_i))
    else begin $error("busy_o rose without start_i"); err_cnt++; end

  // output stream holds valid and data until taken.
  a_rd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o))
    else begin $error("rd stream changed while stalled"); err_cnt++; end

  // a stalled bank grants nothing.
  a_stall_wr: assert property (@(posedge clk_i) disable iff (rst_i)
    bank_stall_i |-> !wr_ready_o)
    else begin $error("wr_ready_o high during bank stall"); err_cnt++; end

endmodule

bind tcdm_stream_subsys tcdm_stream_subsys_sva i_sva (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .start_i      (start_i),
  .busy_o       (busy_o),
  .done_o       (done_o),
  .bank_stall_i (bank_stall_i),
  .rd_valid_o   (rd_valid_o),
  .rd_data_o    (rd_data_o),
  .rd_ready_i   (rd_ready_i),
  .wr_ready_o   (wr_ready_o)
);

/* hdl/hci_core_mux_static.sv */
/*
  Static N-to-1 TCDM mux, purely combinational.
  only valid when the initiators are used strictly one at a time.
  sel_i must hold until every read response of that channel is back.
*/
module hci_core_mux_static #(
  parameter int unsigned NB_CHAN = 2
) (
  input  logic [$clog2(NB_CHAN)-1:0]              sel_i,
  // initiator side.
  input  logic [NB_CHAN-1:0]                      in_req_i,
  input  logic [NB_CHAN-1:0][hci_pkg::HCI_AW-1:0] in_add_i,
  input  logic [NB_CHAN-1:0]                      in_wen_i,
  input  logic [NB_CHAN-1:0][hci_pkg::HCI_DW-1:0] in_data_i,
  input  logic [NB_CHAN-1:0][hci_pkg::HCI_BEW-1:0] in_be_i,
  output logic [NB_CHAN-1:0]                      in_gnt_o,
  output logic [NB_CHAN-1:0]                      in_r_valid_o,
  output logic [NB_CHAN-1:0][hci_pkg::HCI_DW-1:0] in_r_data_o,
  // target side.
  output logic                                    out_req_o,
  output logic [hci_pkg::HCI_AW-1:0]              out_add_o,
  output logic                                    out_wen_o,
  output logic [hci_pkg::HCI_DW-1:0]              out_data_o,
  output logic [hci_pkg::HCI_BEW-1:0]             out_be_o,
  output logic [hci_pkg::HCI_IW-1:0]              out_id_o,
  input  logic                                    out_gnt_i,
  input  logic                                    out_r_valid_i,
  input  logic [hci_pkg::HCI_DW-1:0]              out_r_data_i,
  input  logic [hci_pkg::HCI_IW-1:0]              out_r_id_i
);
  import hci_pkg::*;

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    // grant back to the selected channel only.
    assign in_gnt_o[ii] = (sel_i == ii) ? out_gnt_i : 1'b0;
    // responses follow their id, not the current select.
    assign in_r_valid_o[ii] = (out_r_id_i == ii) ? out_r_valid_i : 1'b0;
    // read data is shared, r_valid qualifies it.
    assign in_r_data_o[ii] = out_r_data_i;
  end

  // request fields of the selected channel.
  assign out_req_o  = in_req_i[sel_i];
  assign out_add_o  = in_add_i[sel_i];
  assign out_wen_o  = in_wen_i[sel_i];
  assign out_data_o = in_data_i[sel_i];
  assign out_be_o   = in_be_i[sel_i];
  // channel index travels as id.
  assign out_id_o   = HCI_IW'(sel_i);

endmodule

/* hdl/hci_job_ctrl.sv */
/*
  Job controller, one job at a time.
  start_i is ignored while busy_o is high.
  sel_o holds for the whole job, which keeps the static mux safe.
*/
module hci_job_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             start_i,
  input  stream_job_pkg::job_op_e          op_i,
  input  logic [hci_pkg::HCI_AW-1:0]       base_i,
  input  logic [stream_job_pkg::LEN_W-1:0] len_i,
  input  logic                             load_done_i,
  input  logic                             store_done_i,
  output logic                             busy_o,
  output logic                             done_o,
  output logic [stream_job_pkg::SEL_W-1:0] sel_o,
  output logic                             load_start_o,
  output logic                             store_start_o,
  output logic [hci_pkg::HCI_AW-1:0]       job_base_o,
  output logic [stream_job_pkg::LEN_W-1:0] job_len_o
);
  import stream_job_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_e;

  state_e  state_q;
  job_op_e op_q;
  logic    accept;
  logic    job_done;

  assign accept = start_i && (state_q == ST_IDLE);
  assign busy_o = (state_q == ST_BUSY);
  assign sel_o  = (op_q == JOB_STORE) ? SEL_W'(STORE_CHAN) : SEL_W'(LOAD_CHAN);
  // only the running streamer can end the job.
  assign job_done = (op_q == JOB_STORE) ? store_done_i : load_done_i;

  // job parameters, zero length runs as one word.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      job_base_o <= base_i;
      job_len_o  <= (len_i == '0) ? LEN_W'(1) : len_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= ST_IDLE;
      op_q          <= JOB_LOAD;
      done_o        <= 1'b0;
      load_start_o  <= 1'b0;
      store_start_o <= 1'b0;
    end else begin
      // start pulse in the cycle busy_o rises.
      load_start_o  <= accept && (op_i == JOB_LOAD);
      store_start_o <= accept && (op_i == JOB_STORE);
      done_o        <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_BUSY;
            op_q    <= op_i;
          end
        end
        ST_BUSY: begin
          // busy_o falls together with the done pulse.
          if (job_done) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* hdl/hci_load_streamer.sv */
/*
  Load streamer: sequential word reads, out on a valid/ready stream.
  len_i must be nonzero; the controller maps zero to one.
  reads in flight plus buffered words never exceed FIFO_DEPTH,
  so the FIFO always has room for a response.
*/
module hci_load_streamer #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             start_i,
  input  logic [hci_pkg::HCI_AW-1:0]       base_i,
  input  logic [stream_job_pkg::LEN_W-1:0] len_i,
  // tcdm initiator.
  output logic                             req_o,
  output logic [hci_pkg::HCI_AW-1:0]       add_o,
  output logic                             wen_o,
  output logic [hci_pkg::HCI_BEW-1:0]      be_o,
  input  logic                             gnt_i,
  input  logic                             r_valid_i,
  input  logic [hci_pkg::HCI_DW-1:0]       r_data_i,
  // output stream.
  output logic                             stream_valid_o,
  output logic [hci_pkg::HCI_DW-1:0]       stream_data_o,
  input  logic                             stream_ready_i,
  output logic                             done_o
);
  import hci_pkg::*;
  import stream_job_pkg::*;

  logic                            active_q;
  logic [LEN_W-1:0]                len_q;
  logic [LEN_W-1:0]                issued_q;
  logic [LEN_W-1:0]                sent_q;
  logic [HCI_AW-1:0]               add_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0] outst_q;
  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_cnt;
  logic [$clog2(FIFO_DEPTH+1):0]   credit_used;
  logic                            rd_xfer;
  logic                            out_xfer;

  // credits taken by reads in flight and buffered words.
  assign credit_used = {1'b0, outst_q} + {1'b0, fifo_cnt};
  // sum cannot grow while waiting, so req holds until granted.
  assign req_o = active_q && (issued_q != len_q) && (credit_used < FIFO_DEPTH);
  assign add_o = add_q;
  assign wen_o = 1'b1;
  assign be_o  = '1;
  assign rd_xfer  = req_o & gnt_i;
  assign out_xfer = stream_valid_o & stream_ready_i;
  // done with the last word leaving, all responses are in by then.
  assign done_o = active_q && out_xfer && (sent_q == len_q - 1'b1);

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_q <= len_i;
      add_q <= base_i;
    end else if (rd_xfer) begin
      add_q <= add_q + HCI_AW'(HCI_BEW);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      issued_q <= '0;
      sent_q   <= '0;
      outst_q  <= '0;
    end else begin
      if (start_i) begin
        active_q <= 1'b1;
        issued_q <= '0;
        sent_q   <= '0;
      end else begin
        if (done_o) begin
          active_q <= 1'b0;
        end
        if (rd_xfer) begin
          issued_q <= issued_q + 1'b1;
        end
        if (out_xfer) begin
          sent_q <= sent_q + 1'b1;
        end
      end
      // outstanding reads, up on grant, down on response.
      if (rd_xfer && !r_valid_i) begin
        outst_q <= outst_q + 1'b1;
      end else if (r_valid_i && !rd_xfer) begin
        outst_q <= outst_q - 1'b1;
      end
    end
  end

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fifo (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (r_valid_i),
    .push_data_i  (r_data_i),
    .push_ready_o (),
    .pop_valid_o  (stream_valid_o),
    .pop_data_o   (stream_data_o),
    .pop_ready_i  (stream_ready_i),
    .count_o      (fifo_cnt)
  );

endmodule

/* hdl/hci_pkg.sv */
/*
  TCDM bus geometry shared by the streamers, the mux and the bank.
  addresses are byte addresses, but every access is one full word.
  there is a single bank of MEM_WORDS words and no interleaving.
*/
package hci_pkg;

  // byte address width of the tcdm port.
  localparam int unsigned HCI_AW = 16;
  // data word width.
  localparam int unsigned HCI_DW = 32;
  // bits per byte lane.
  localparam int unsigned HCI_BW = 8;
  // byte enables per word.
  localparam int unsigned HCI_BEW = HCI_DW / HCI_BW;
  // response id, one bit covers two initiators.
  localparam int unsigned HCI_IW = 1;

  // bank depth in words.
  localparam int unsigned MEM_WORDS = 256;
  // word index width, and the byte offset below it.
  localparam int unsigned MEM_AW = $clog2(MEM_WORDS);
  localparam int unsigned WORD_OFFS = $clog2(HCI_BEW);

endpackage

/* hdl/hci_store_streamer.sv */
/*
  Store streamer: stream words written to sequential addresses.
  len_i must be nonzero. ready is given only with the write grant,
  so ready depends combinationally on valid and on the bank grant.
*/
module hci_store_streamer (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             start_i,
  input  logic [hci_pkg::HCI_AW-1:0]       base_i,
  input  logic [stream_job_pkg::LEN_W-1:0] len_i,
  // tcdm initiator.
  output logic                             req_o,
  output logic [hci_pkg::HCI_AW-1:0]       add_o,
  output logic                             wen_o,
  output logic [hci_pkg::HCI_DW-1:0]       data_o,
  output logic [hci_pkg::HCI_BEW-1:0]      be_o,
  input  logic                             gnt_i,
  // input stream.
  input  logic                             stream_valid_i,
  input  logic [hci_pkg::HCI_DW-1:0]       stream_data_i,
  output logic                             stream_ready_o,
  output logic                             done_o
);
  import hci_pkg::*;
  import stream_job_pkg::*;

  logic              active_q;
  logic              done_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  cnt_q;
  logic [HCI_AW-1:0] add_q;
  logic              wr_xfer;
  logic              last;

  // stream word goes straight onto the bus.
  assign req_o  = active_q & stream_valid_i;
  assign add_o  = add_q;
  assign wen_o  = 1'b0;
  assign data_o = stream_data_i;
  assign be_o   = '1;
  assign wr_xfer = req_o & gnt_i;
  // word consumed by the grant.
  assign stream_ready_o = wr_xfer;
  assign last = wr_xfer && (cnt_q == len_q - 1'b1);
  assign done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      len_q <= len_i;
      add_q <= base_i;
    end else if (wr_xfer) begin
      add_q <= add_q + HCI_AW'(HCI_BEW);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      cnt_q    <= '0;
    end else begin
      // done one cycle after the last grant.
      done_q <= last;
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (wr_xfer) begin
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          active_q <= 1'b0;
        end
      end
    end
  end

endmodule

/* hdl/stream_fifo.sv */
/*
  Synchronous valid/ready FIFO with an occupancy count.
  FIFO_DEPTH must be a power of two, at least 2.
  a pushed word shows on the output the next cycle; no bypass.
*/
module stream_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              push_valid_i,
  input  logic [hci_pkg::HCI_DW-1:0]        push_data_i,
  output logic                              push_ready_o,
  output logic                              pop_valid_o,
  output logic [hci_pkg::HCI_DW-1:0]        pop_data_o,
  input  logic                              pop_ready_i,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]   count_o
);
  import hci_pkg::*;

  logic [HCI_DW-1:0]             mem_q [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
  logic                          push;
  logic                          pop;

  assign push_ready_o = (count_o != FIFO_DEPTH);
  assign pop_valid_o  = (count_o != '0);
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;
  // head of the buffer.
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap on their own width.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_o <= count_o + 1'b1;
      end else if (pop && !push) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

endmodule

/* hdl/stream_job_pkg.sv */
/*
  Job encoding for the load and store streamers.
  a job moves 1 to 255 words; a length of zero runs as one word.
  the channel numbers fix the order of the static mux inputs.
*/
package stream_job_pkg;

  // job length width.
  localparam int unsigned LEN_W = 8;

  // job kind, picks the streamer.
  typedef enum logic {
    JOB_LOAD  = 1'b0,
    JOB_STORE = 1'b1
  } job_op_e;

  // mux channels behind the controller.
  localparam int unsigned NB_STREAM_CHAN = 2;
  localparam int unsigned SEL_W = $clog2(NB_STREAM_CHAN);
  localparam int unsigned LOAD_CHAN = 0;
  localparam int unsigned STORE_CHAN = 1;

endpackage

/* hdl/tcdm_mem_bank.sv */
/*
  Single-port TCDM bank model of MEM_WORDS words.
  grants in the request cycle unless stall_i is high.
  reads answer exactly one cycle after the grant; writes get no response.
  contents are not cleared by reset; upper address bits are ignored.
*/
module tcdm_mem_bank (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        stall_i,
  input  logic                        req_i,
  input  logic [hci_pkg::HCI_AW-1:0]  add_i,
  input  logic                        wen_i,
  input  logic [hci_pkg::HCI_DW-1:0]  data_i,
  input  logic [hci_pkg::HCI_BEW-1:0] be_i,
  input  logic [hci_pkg::HCI_IW-1:0]  id_i,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [hci_pkg::HCI_DW-1:0]  r_data_o,
  output logic [hci_pkg::HCI_IW-1:0]  r_id_o
);
  import hci_pkg::*;

  logic [HCI_DW-1:0] mem_q [MEM_WORDS];
  logic [MEM_AW-1:0] idx;

  // word index from the byte address.
  assign idx = add_i[WORD_OFFS +: MEM_AW];
  assign gnt_o = req_i & ~stall_i;

  // granted write, byte lanes by be_i.
  always_ff @(posedge clk_i) begin
    if (gnt_o && !wen_i) begin
      for (int b = 0; b < HCI_BEW; b++) begin
        if (be_i[b]) begin
          mem_q[idx][b*HCI_BW +: HCI_BW] <= data_i[b*HCI_BW +: HCI_BW];
        end
      end
    end
  end

  // read word and id captured at grant.
  always_ff @(posedge clk_i) begin
    if (gnt_o && wen_i) begin
      r_data_o <= mem_q[idx];
      r_id_o   <= id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_o <= 1'b0;
    end else begin
      r_valid_o <= gnt_o & wen_i;
    end
  end

endmodule

/* hdl/tcdm_stream_subsys.sv */
/*
  TCDM stream subsystem: job controller, load and store streamers,
  static mux and one bank. one job runs at a time.
  bank_stall_i holds off bank grants for testing back-pressure.
*/
module tcdm_stream_subsys (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             start_i,
  input  stream_job_pkg::job_op_e          op_i,
  input  logic [hci_pkg::HCI_AW-1:0]       base_i,
  input  logic [stream_job_pkg::LEN_W-1:0] len_i,
  output logic                             busy_o,
  output logic                             done_o,
  input  logic                             bank_stall_i,
  output logic                             rd_valid_o,
  output logic [hci_pkg::HCI_DW-1:0]       rd_data_o,
  input  logic                             rd_ready_i,
  input  logic                             wr_valid_i,
  input  logic [hci_pkg::HCI_DW-1:0]       wr_data_i,
  output logic                             wr_ready_o
);
  import hci_pkg::*;
  import stream_job_pkg::*;

  // controller to streamers.
  logic [SEL_W-1:0]  sel;
  logic              load_start;
  logic              store_start;
  logic              load_done;
  logic              store_done;
  logic [HCI_AW-1:0] job_base;
  logic [LEN_W-1:0]  job_len;

  // mux inputs, indexed by channel.
  logic [NB_STREAM_CHAN-1:0]              ch_req;
  logic [NB_STREAM_CHAN-1:0][HCI_AW-1:0]  ch_add;
  logic [NB_STREAM_CHAN-1:0]              ch_wen;
  logic [NB_STREAM_CHAN-1:0][HCI_DW-1:0]  ch_data;
  logic [NB_STREAM_CHAN-1:0][HCI_BEW-1:0] ch_be;
  logic [NB_STREAM_CHAN-1:0]              ch_gnt;
  logic [NB_STREAM_CHAN-1:0]              ch_r_valid;
  logic [NB_STREAM_CHAN-1:0][HCI_DW-1:0]  ch_r_data;

  // mux to bank.
  logic               bank_req;
  logic [HCI_AW-1:0]  bank_add;
  logic               bank_wen;
  logic [HCI_DW-1:0]  bank_data;
  logic [HCI_BEW-1:0] bank_be;
  logic [HCI_IW-1:0]  bank_id;
  logic               bank_gnt;
  logic               bank_r_valid;
  logic [HCI_DW-1:0]  bank_r_data;
  logic [HCI_IW-1:0]  bank_r_id;

  // load channel never writes.
  assign ch_data[LOAD_CHAN] = '0;

  hci_job_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .start_i       (start_i),
    .op_i          (op_i),
    .base_i        (base_i),
    .len_i         (len_i),
    .load_done_i   (load_done),
    .store_done_i  (store_done),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .sel_o         (sel),
    .load_start_o  (load_start),
    .store_start_o (store_start),
    .job_base_o    (job_base),
    .job_len_o     (job_len)
  );

  hci_load_streamer i_load (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (load_start),
    .base_i         (job_base),
    .len_i          (job_len),
    .req_o          (ch_req[LOAD_CHAN]),
    .add_o          (ch_add[LOAD_CHAN]),
    .wen_o          (ch_wen[LOAD_CHAN]),
    .be_o           (ch_be[LOAD_CHAN]),
    .gnt_i          (ch_gnt[LOAD_CHAN]),
    .r_valid_i      (ch_r_valid[LOAD_CHAN]),
    .r_data_i       (ch_r_data[LOAD_CHAN]),
    .stream_valid_o (rd_valid_o),
    .stream_data_o  (rd_data_o),
    .stream_ready_i (rd_ready_i),
    .done_o         (load_done)
  );

  hci_store_streamer i_store (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (store_start),
    .base_i         (job_base),
    .len_i          (job_len),
    .req_o          (ch_req[STORE_CHAN]),
    .add_o          (ch_add[STORE_CHAN]),
    .wen_o          (ch_wen[STORE_CHAN]),
    .data_o         (ch_data[STORE_CHAN]),
    .be_o           (ch_be[STORE_CHAN]),
    .gnt_i          (ch_gnt[STORE_CHAN]),
    .stream_valid_i (wr_valid_i),
    .stream_data_i  (wr_data_i),
    .stream_ready_o (wr_ready_o),
    .done_o         (store_done)
  );

  hci_core_mux_static #(
    .NB_CHAN (NB_STREAM_CHAN)
  ) i_mux (
    .sel_i         (sel),
    .in_req_i      (ch_req),
    .in_add_i      (ch_add),
    .in_wen_i      (ch_wen),
    .in_data_i     (ch_data),
    .in_be_i       (ch_be),
    .in_gnt_o      (ch_gnt),
    .in_r_valid_o  (ch_r_valid),
    .in_r_data_o   (ch_r_data),
    .out_req_o     (bank_req),
    .out_add_o     (bank_add),
    .out_wen_o     (bank_wen),
    .out_data_o    (bank_data),
    .out_be_o      (bank_be),
    .out_id_o      (bank_id),
    .out_gnt_i     (bank_gnt),
    .out_r_valid_i (bank_r_valid),
    .out_r_data_i  (bank_r_data),
    .out_r_id_i    (bank_r_id)
  );

  tcdm_mem_bank i_bank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .stall_i   (bank_stall_i),
    .req_i     (bank_req),
    .add_i     (bank_add),
    .wen_i     (bank_wen),
    .data_i    (bank_data),
    .be_i      (bank_be),
    .id_i      (bank_id),
    .gnt_o     (bank_gnt),
    .r_valid_o (bank_r_valid),
    .r_data_o  (bank_r_data),
    .r_id_o    (bank_r_id)
  );

endmodule
